/* Bender.yml */
package:
  name: ooo_core

sources:
  - include_dirs:
      - .
    files:
      - ooo_isa_pkg.sv
      - ooo_uarch_pkg.sv
      - rename_unit.sv
      - phys_regfile.sv
      - reorder_buffer.sv
      - reservation_station.sv
      - alu_unit.sv
      - mult_unit.sv
      - cdb_arbiter.sv
      - ooo_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ooo_core.sv

/* alu_unit.sv */
/*
  single-cycle alu for ADD, SUB and LI
  result is held with req high until the bus grants it
*/
`timescale 1ns/100ps

module alu_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     issue_valid,
  input  ooo_isa_pkg::op_e         op,
  input  ooo_isa_pkg::word_t       a,
  input  ooo_isa_pkg::word_t       b,
  input  ooo_uarch_pkg::phys_tag_t tag,
  input  ooo_uarch_pkg::rob_idx_t  rob,
  input  logic                     grant,
  output logic                     req,
  output ooo_uarch_pkg::phys_tag_t res_tag,
  output ooo_uarch_pkg::rob_idx_t  res_rob,
  output ooo_isa_pkg::word_t       res_data,
  output logic                     credit
);

  assign credit = req & grant;  // slot freed as the result leaves

  always_ff @(posedge clock) begin
    if (reset) req <= 1'b0;
    else if (issue_valid) req <= 1'b1;  // request one cycle after issue
    else if (grant) req <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (issue_valid) begin
      res_tag <= tag;
      res_rob <= rob;
      case (op)
        ooo_isa_pkg::ADD: res_data <= a + b;
        ooo_isa_pkg::SUB: res_data <= a - b;
        default:          res_data <= a;  // LI passes the immediate
      endcase
    end
  end

endmodule

/* cdb_arbiter.sv */
/*
  common data bus arbiter and driver
  multiplier wins by default; the alu jumps ahead after repeated losses
*/
`timescale 1ns/100ps

module cdb_arbiter (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     alu_req,
  input  logic                     mult_req,
  input  ooo_uarch_pkg::phys_tag_t alu_tag,
  input  ooo_uarch_pkg::phys_tag_t mult_tag,
  input  ooo_uarch_pkg::rob_idx_t  alu_rob,
  input  ooo_uarch_pkg::rob_idx_t  mult_rob,
  input  ooo_isa_pkg::word_t       alu_data,
  input  ooo_isa_pkg::word_t       mult_data,
  output logic                     alu_grant,
  output logic                     mult_grant,
  output logic                     cdb_valid,
  output ooo_uarch_pkg::phys_tag_t cdb_tag,
  output ooo_uarch_pkg::rob_idx_t  cdb_rob,
  output ooo_isa_pkg::word_t       cdb_data
);

  localparam logic [2:0] MAX_LOSSES = 3'd4;

  logic [2:0] alu_losses;  // consecutive cycles the alu asked and lost

  assign alu_grant  = alu_req && (!mult_req || alu_losses == MAX_LOSSES);
  assign mult_grant = mult_req && !alu_grant;

  // bus is live only in the granted cycle
  assign cdb_valid = alu_grant | mult_grant;
  assign cdb_tag   = mult_grant ? mult_tag  : alu_tag;
  assign cdb_rob   = mult_grant ? mult_rob  : alu_rob;
  assign cdb_data  = mult_grant ? mult_data : alu_data;

  always_ff @(posedge clock) begin
    if (reset || alu_grant) alu_losses <= '0;
    else if (alu_req) alu_losses <= alu_losses + 1'b1;  // stops at 4, granted then
  end

endmodule

/* mult_unit.sv */
/*
  iterative shift-add multiplier, one partial product per cycle
  low word of the product only; req held in DONE until granted
*/
`timescale 1ns/100ps
`include "ooo_config.svh"

module mult_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     issue_valid,
  input  ooo_isa_pkg::word_t       a,
  input  ooo_isa_pkg::word_t       b,
  input  ooo_uarch_pkg::phys_tag_t tag,
  input  ooo_uarch_pkg::rob_idx_t  rob,
  input  logic                     grant,
  output logic                     req,
  output ooo_uarch_pkg::phys_tag_t res_tag,
  output ooo_uarch_pkg::rob_idx_t  res_rob,
  output ooo_isa_pkg::word_t       res_data,
  output logic                     credit
);

  localparam int              STEP_W = $clog2(`OOO_DATA_W);
  localparam logic [STEP_W-1:0] LAST = STEP_W'(`OOO_DATA_W - 1);

  ooo_uarch_pkg::mult_state_e state;
  logic [STEP_W-1:0]          step;          // steps already taken
  ooo_isa_pkg::word_t         mcand, mplier; // shifted operands

  assign req    = (state == ooo_uarch_pkg::DONE);
  assign credit = req & grant;

  //////////////////////////////////////////////////////////////////////////
  // sequencing: first step at issue, 31 more in BUSY, req on cycle 32
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ooo_uarch_pkg::IDLE;
      step  <= '0;
    end else begin
      case (state)
        ooo_uarch_pkg::IDLE: if (issue_valid) begin
          state <= ooo_uarch_pkg::BUSY;
          step  <= STEP_W'(1);
        end
        ooo_uarch_pkg::BUSY: begin
          step <= step + 1'b1;
          if (step == LAST) state <= ooo_uarch_pkg::DONE;
        end
        ooo_uarch_pkg::DONE: if (grant) state <= ooo_uarch_pkg::IDLE;
        default: state <= ooo_uarch_pkg::IDLE;
      endcase
    end
  end

  // datapath, res_data is the accumulator
  always_ff @(posedge clock) begin
    if (state == ooo_uarch_pkg::IDLE && issue_valid) begin
      res_tag  <= tag;
      res_rob  <= rob;
      res_data <= b[0] ? a : '0;
      mcand    <= a << 1;
      mplier   <= b >> 1;
    end else if (state == ooo_uarch_pkg::BUSY) begin
      if (mplier[0]) res_data <= res_data + mcand;
      mcand  <= mcand << 1;   // high bits fall off, low word kept
      mplier <= mplier >> 1;
    end
  end

endmodule

/* ooo_config.svh */
/*
  sizing for the renaming core slice
  included by both packages and by every module that sizes its arrays
*/
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// architectural registers r0..r7
`define OOO_ARCH_REGS 8

// physical registers, the arch set plus rename headroom
`define OOO_PHYS_REGS 16

// rob depth, also the rs slot count and the dispatch credit count
`define OOO_ROB_DEPTH 8

// datapath width, also the multiplier step count
`define OOO_DATA_W 32

`endif

/* ooo_core.sv */
/*
  top of the renaming core slice: rename, regfile, rob, rs, two units, bus
  dispatch side runs on credits, one returned per retired instruction
*/
`timescale 1ns/100ps

module ooo_core (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   in_valid,
  input  ooo_isa_pkg::op_e       in_op,
  input  ooo_isa_pkg::arch_reg_t in_dest,
  input  ooo_isa_pkg::arch_reg_t in_src1,
  input  ooo_isa_pkg::arch_reg_t in_src2,
  input  ooo_isa_pkg::word_t     in_imm,
  output logic                   credit_return,
  output logic                   commit_valid,
  output ooo_isa_pkg::arch_reg_t commit_dest,
  output ooo_isa_pkg::word_t     commit_data
);

  ooo_uarch_pkg::phys_tag_t src1_tag, src2_tag, new_tag, old_tag, retire_old_tag;
  ooo_uarch_pkg::phys_tag_t issue_tag, alu_tag, mult_tag, cdb_tag;
  ooo_uarch_pkg::rob_idx_t  tail_idx, issue_rob, alu_rob, mult_rob, cdb_rob;
  ooo_isa_pkg::word_t       rd1_data, rd2_data, issue_a, issue_b;
  ooo_isa_pkg::word_t       alu_data, mult_data, cdb_data;
  ooo_isa_pkg::op_e         issue_op;
  logic                     rd1_ready, rd2_ready, retire, cdb_valid;
  logic                     issue_alu_valid, issue_mult_valid;
  logic                     alu_req, mult_req, alu_grant, mult_grant;
  logic                     alu_credit, mult_credit;

  // a retirement is both the commit and the returned credit
  assign commit_valid  = retire;
  assign credit_return = retire;

  rename_unit rename_i (
    .clock, .reset, .dispatch(in_valid), .src1(in_src1), .src2(in_src2),
    .dest(in_dest), .retire, .retire_old_tag, .src1_tag, .src2_tag, .new_tag, .old_tag
  );

  phys_regfile prf_i (
    .clock, .reset, .alloc(in_valid), .alloc_tag(new_tag), .rd1_tag(src1_tag),
    .rd2_tag(src2_tag), .cdb_valid, .cdb_tag, .cdb_data,
    .rd1_data, .rd2_data, .rd1_ready, .rd2_ready
  );

  reorder_buffer rob_i (
    .clock, .reset, .dispatch(in_valid), .dest(in_dest), .old_tag, .cdb_valid,
    .cdb_rob, .cdb_data, .tail_idx, .retire, .retire_dest(commit_dest),
    .retire_old_tag, .retire_data(commit_data)
  );

  reservation_station rs_i (
    .clock, .reset, .dispatch(in_valid), .op(in_op), .imm(in_imm), .rob(tail_idx),
    .dest_tag(new_tag), .src1_tag, .src2_tag, .src1_ready(rd1_ready),
    .src2_ready(rd2_ready), .src1_data(rd1_data), .src2_data(rd2_data),
    .cdb_valid, .cdb_tag, .cdb_data, .alu_credit, .mult_credit,
    .issue_alu_valid, .issue_mult_valid, .issue_op, .issue_a, .issue_b,
    .issue_tag, .issue_rob
  );

  alu_unit alu_i (
    .clock, .reset, .issue_valid(issue_alu_valid), .op(issue_op), .a(issue_a),
    .b(issue_b), .tag(issue_tag), .rob(issue_rob), .grant(alu_grant), .req(alu_req),
    .res_tag(alu_tag), .res_rob(alu_rob), .res_data(alu_data), .credit(alu_credit)
  );

  mult_unit mult_i (
    .clock, .reset, .issue_valid(issue_mult_valid), .a(issue_a), .b(issue_b),
    .tag(issue_tag), .rob(issue_rob), .grant(mult_grant), .req(mult_req),
    .res_tag(mult_tag), .res_rob(mult_rob), .res_data(mult_data), .credit(mult_credit)
  );

  cdb_arbiter cdb_i (
    .clock, .reset, .alu_req, .mult_req, .alu_tag, .mult_tag, .alu_rob, .mult_rob,
    .alu_data, .mult_data, .alu_grant, .mult_grant, .cdb_valid, .cdb_tag, .cdb_rob,
    .cdb_data
  );

endmodule

/* ooo_isa_pkg.sv */
/*
  instruction-set types seen at the dispatch and commit ports
  referenced by scoped name, ooo_isa_pkg::word_t and so on
*/
`include "ooo_config.svh"

package ooo_isa_pkg;

  // opcode field, 2 bits
  typedef enum logic [1:0] {
    ADD = 2'b00,  // rd = rs1 + rs2
    SUB = 2'b01,  // rd = rs1 - rs2
    MUL = 2'b10,  // rd = low word of rs1 * rs2
    LI  = 2'b11   // rd = imm
  } op_e;

  // architectural register index
  typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arch_reg_t;

  typedef logic [`OOO_DATA_W-1:0] word_t;  // register and bus value

endpackage

/* ooo_uarch_pkg.sv */
/*
  microarchitecture types: rename tags, rob slots, unit states
  referenced by scoped name from the core blocks
*/
`include "ooo_config.svh"

package ooo_uarch_pkg;

  // physical register tag, also the name a result carries on the bus
  typedef logic [$clog2(`OOO_PHYS_REGS)-1:0] phys_tag_t;

  // reorder buffer slot
  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;

  // iterative multiplier sequencing
  typedef enum logic [1:0] {
    IDLE = 2'b00,  // free, waiting for issue
    BUSY = 2'b01,  // shift-add steps running
    DONE = 2'b10   // result held, bus requested
  } mult_state_e;

endpackage

/* phys_regfile.sv */
/*
  physical register file with one ready bit per tag
  written from the result bus, read twice at dispatch with bus bypass
*/
`timescale 1ns/100ps
`include "ooo_config.svh"

module phys_regfile (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     alloc,
  input  ooo_uarch_pkg::phys_tag_t alloc_tag,
  input  ooo_uarch_pkg::phys_tag_t rd1_tag,
  input  ooo_uarch_pkg::phys_tag_t rd2_tag,
  input  logic                     cdb_valid,
  input  ooo_uarch_pkg::phys_tag_t cdb_tag,
  input  ooo_isa_pkg::word_t       cdb_data,
  output ooo_isa_pkg::word_t       rd1_data,
  output ooo_isa_pkg::word_t       rd2_data,
  output logic                     rd1_ready,
  output logic                     rd2_ready
);

  ooo_isa_pkg::word_t        vals  [`OOO_PHYS_REGS];
  logic [`OOO_PHYS_REGS-1:0] ready;
  logic                      hit1, hit2;  // bus writing the tag being read

  assign hit1 = cdb_valid && (cdb_tag == rd1_tag);
  assign hit2 = cdb_valid && (cdb_tag == rd2_tag);

  assign rd1_data  = hit1 ? cdb_data : vals[rd1_tag];
  assign rd2_data  = hit2 ? cdb_data : vals[rd2_tag];
  assign rd1_ready = hit1 | ready[rd1_tag];
  assign rd2_ready = hit2 | ready[rd2_tag];

  always_ff @(posedge clock) begin
    if (reset) begin
      // arch state starts as all zero, every tag valid
      for (int t = 0; t < `OOO_PHYS_REGS; t++) begin
        vals[t] <= '0;
      end
      ready <= '1;
    end else begin
      if (alloc) ready[alloc_tag] <= 1'b0;  // new producer pending
      if (cdb_valid) begin
        vals[cdb_tag]  <= cdb_data;
        ready[cdb_tag] <= 1'b1;
      end
    end
  end

endmodule

/* project.f */
+incdir+.
ooo_isa_pkg.sv
ooo_uarch_pkg.sv
rename_unit.sv
phys_regfile.sv
reorder_buffer.sv
reservation_station.sv
alu_unit.sv
mult_unit.sv
cdb_arbiter.sv
ooo_core.sv
tb_ooo_core.sv

/* rename_unit.sv */
/*
  register rename stage: speculative map table plus free-list FIFO
  one dispatch and one retire per cycle, both may land in the same cycle
*/
`timescale 1ns/100ps
`include "ooo_config.svh"

module rename_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch,
  input  ooo_isa_pkg::arch_reg_t   src1,
  input  ooo_isa_pkg::arch_reg_t   src2,
  input  ooo_isa_pkg::arch_reg_t   dest,
  input  logic                     retire,
  input  ooo_uarch_pkg::phys_tag_t retire_old_tag,
  output ooo_uarch_pkg::phys_tag_t src1_tag,
  output ooo_uarch_pkg::phys_tag_t src2_tag,
  output ooo_uarch_pkg::phys_tag_t new_tag,
  output ooo_uarch_pkg::phys_tag_t old_tag
);

  localparam int FREE_N = `OOO_PHYS_REGS - `OOO_ARCH_REGS;  // tags not mapped at reset
  localparam int PTR_W  = $clog2(FREE_N);

  ooo_uarch_pkg::phys_tag_t map_q  [`OOO_ARCH_REGS];  // arch reg -> newest tag
  ooo_uarch_pkg::phys_tag_t free_q [FREE_N];          // circular free list
  logic [PTR_W-1:0]         fl_head;                  // next tag handed out
  logic [PTR_W-1:0]         fl_tail;                  // where a freed tag lands

  // lookups read the registered map, which already holds last cycle's rename
  assign src1_tag = map_q[src1];
  assign src2_tag = map_q[src2];
  assign old_tag  = map_q[dest];   // goes to the rob, freed at retire
  assign new_tag  = free_q[fl_head];

  //////////////////////////////////////////////////////////////////////////
  // map table and free list
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
        map_q[r] <= ooo_uarch_pkg::phys_tag_t'(r);  // identity map
      end
      for (int i = 0; i < FREE_N; i++) begin
        free_q[i] <= ooo_uarch_pkg::phys_tag_t'(`OOO_ARCH_REGS + i);  // tags 8..15
      end
      fl_head <= '0;
      fl_tail <= '0;  // head == tail with all slots filled, list full
    end else begin
      if (dispatch) begin
        map_q[dest] <= free_q[fl_head];  // pop and remap
        fl_head     <= fl_head + 1'b1;
      end
      // credits cap in-flight work, so a push never overruns the head
      if (retire) begin
        free_q[fl_tail] <= retire_old_tag;
        fl_tail         <= fl_tail + 1'b1;
      end
    end
  end

endmodule

/* reorder_buffer.sv */
/*
  reorder buffer: circular, filled at the tail by dispatch, drained in order
  the retire pulse doubles as commit strobe and dispatch credit
*/
`timescale 1ns/100ps
`include "ooo_config.svh"

module reorder_buffer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch,
  input  ooo_isa_pkg::arch_reg_t   dest,
  input  ooo_uarch_pkg::phys_tag_t old_tag,
  input  logic                     cdb_valid,
  input  ooo_uarch_pkg::rob_idx_t  cdb_rob,
  input  ooo_isa_pkg::word_t       cdb_data,
  output ooo_uarch_pkg::rob_idx_t  tail_idx,
  output logic                     retire,
  output ooo_isa_pkg::arch_reg_t   retire_dest,
  output ooo_uarch_pkg::phys_tag_t retire_old_tag,
  output ooo_isa_pkg::word_t       retire_data
);

  localparam int N = `OOO_ROB_DEPTH;

  logic [N-1:0]             valid;  // slot holds an instruction
  logic [N-1:0]             done;   // result seen on the bus
  ooo_isa_pkg::arch_reg_t   ent_dest [N];
  ooo_uarch_pkg::phys_tag_t ent_old  [N];
  ooo_isa_pkg::word_t       ent_data [N];
  ooo_uarch_pkg::rob_idx_t  head, tail;

  assign tail_idx = tail;

  // retire the head once complete, one per cycle
  assign retire         = valid[head] & done[head];
  assign retire_dest    = ent_dest[head];
  assign retire_old_tag = ent_old[head];
  assign retire_data    = ent_data[head];

  //////////////////////////////////////////////////////////////////////////
  // pointers and status bits
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
    end else begin
      if (cdb_valid) done[cdb_rob] <= 1'b1;
      if (retire) begin
        valid[head] <= 1'b0;
        head        <= head + 1'b1;  // depth is a power of two, wraps
      end
      // no dispatch while full, credits see to that
      if (dispatch) begin
        valid[tail] <= 1'b1;
        done[tail]  <= 1'b0;
        tail        <= tail + 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    if (dispatch) begin
      ent_dest[tail] <= dest;
      ent_old[tail]  <= old_tag;
    end
    if (cdb_valid) ent_data[cdb_rob] <= cdb_data;  // kept for commit
  end

endmodule

/* reservation_station.sv */
/*
  unified reservation station in front of the alu and the multiplier
  slots snoop the bus; the oldest ready slot issues when its unit holds a credit
*/
`timescale 1ns/100ps
`include "ooo_config.svh"

module reservation_station (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch,
  input  ooo_isa_pkg::op_e         op,
  input  ooo_isa_pkg::word_t       imm,
  input  ooo_uarch_pkg::rob_idx_t  rob,
  input  ooo_uarch_pkg::phys_tag_t dest_tag,
  input  ooo_uarch_pkg::phys_tag_t src1_tag,
  input  ooo_uarch_pkg::phys_tag_t src2_tag,
  input  logic                     src1_ready,
  input  logic                     src2_ready,
  input  ooo_isa_pkg::word_t       src1_data,
  input  ooo_isa_pkg::word_t       src2_data,
  input  logic                     cdb_valid,
  input  ooo_uarch_pkg::phys_tag_t cdb_tag,
  input  ooo_isa_pkg::word_t       cdb_data,
  input  logic                     alu_credit,
  input  logic                     mult_credit,
  output logic                     issue_alu_valid,
  output logic                     issue_mult_valid,
  output ooo_isa_pkg::op_e         issue_op,
  output ooo_isa_pkg::word_t       issue_a,
  output ooo_isa_pkg::word_t       issue_b,
  output ooo_uarch_pkg::phys_tag_t issue_tag,
  output ooo_uarch_pkg::rob_idx_t  issue_rob
);

  localparam int N     = `OOO_ROB_DEPTH;  // never more slots than rob entries
  localparam int IDX_W = $clog2(N);

  logic [N-1:0]             busy, a_rdy, b_rdy;
  ooo_isa_pkg::op_e         s_op   [N];
  ooo_uarch_pkg::phys_tag_t s_dest [N], a_tag [N], b_tag [N];
  ooo_uarch_pkg::rob_idx_t  s_rob  [N];
  ooo_isa_pkg::word_t       a_val  [N], b_val [N];
  logic [IDX_W-1:0]         age    [N];  // dispatches seen since entry, larger is older
  logic [1:0]               alu_cred, mult_cred;

  logic                     found, d_a_rdy, d_b_rdy;
  logic [IDX_W-1:0]         sel, best_age, free_slot;
  ooo_isa_pkg::word_t       d_a, d_b;

  //////////////////////////////////////////////////////////////////////////
  // select: oldest slot with both operands and a credit for its unit
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    found    = 1'b0;
    sel      = '0;
    best_age = '0;
    for (int i = 0; i < N; i++) begin
      if (busy[i] && a_rdy[i] && b_rdy[i] &&
          ((s_op[i] == ooo_isa_pkg::MUL) ? (mult_cred != 2'd0) : (alu_cred != 2'd0)) &&
          (!found || age[i] > best_age)) begin
        found    = 1'b1;
        sel      = IDX_W'(i);
        best_age = age[i];
      end
    end
  end

  assign issue_mult_valid = found && (s_op[sel] == ooo_isa_pkg::MUL);
  assign issue_alu_valid  = found && (s_op[sel] != ooo_isa_pkg::MUL);
  assign issue_op  = s_op[sel];
  assign issue_a   = a_val[sel];
  assign issue_b   = b_val[sel];
  assign issue_tag = s_dest[sel];
  assign issue_rob = s_rob[sel];

  // lowest empty slot for dispatch
  always_comb begin
    free_slot = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!busy[i]) free_slot = IDX_W'(i);
    end
  end

  // operands at dispatch, bus snooped in the same cycle
  always_comb begin
    if (op == ooo_isa_pkg::LI) begin
      d_a_rdy = 1'b1;  // immediate rides as operand a
      d_a     = imm;
      d_b_rdy = 1'b1;
      d_b     = '0;
    end else begin
      d_a_rdy = src1_ready || (cdb_valid && cdb_tag == src1_tag);
      d_a     = src1_ready ? src1_data : cdb_data;
      d_b_rdy = src2_ready || (cdb_valid && cdb_tag == src2_tag);
      d_b     = src2_ready ? src2_data : cdb_data;
    end
  end

  // occupancy and per-unit credits, one credit each out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      busy      <= '0;
      alu_cred  <= 2'd1;
      mult_cred <= 2'd1;
    end else begin
      if (found) busy[sel] <= 1'b0;
      if (dispatch) busy[free_slot] <= 1'b1;
      alu_cred  <= alu_cred + 2'(alu_credit) - 2'(issue_alu_valid);
      mult_cred <= mult_cred + 2'(mult_credit) - 2'(issue_mult_valid);
    end
  end

  // slot payload, operand capture and aging
  always_ff @(posedge clock) begin
    for (int i = 0; i < N; i++) begin
      if (busy[i] && cdb_valid && !a_rdy[i] && a_tag[i] == cdb_tag) begin
        a_rdy[i] <= 1'b1;
        a_val[i] <= cdb_data;
      end
      if (busy[i] && cdb_valid && !b_rdy[i] && b_tag[i] == cdb_tag) begin
        b_rdy[i] <= 1'b1;
        b_val[i] <= cdb_data;
      end
      if (dispatch && busy[i]) age[i] <= age[i] + 1'b1;
    end
    if (dispatch) begin
      s_op[free_slot]   <= op;
      s_dest[free_slot] <= dest_tag;
      s_rob[free_slot]  <= rob;
      a_tag[free_slot]  <= src1_tag;
      b_tag[free_slot]  <= src2_tag;
      a_rdy[free_slot]  <= d_a_rdy;
      b_rdy[free_slot]  <= d_b_rdy;
      a_val[free_slot]  <= d_a;
      b_val[free_slot]  <= d_b;
      age[free_slot]    <= '0;  // youngest
    end
  end

endmodule

/* tb_ooo_core.sv */
/*
  testbench for the renaming core slice
  drives dispatches under credits, mirrors each result in a reference model,
  and checks commits in program order with concurrent assertions
*/
`timescale 1ns/100ps
`include "ooo_config.svh"

module tb_ooo_core;

  localparam int DEPTH   = `OOO_ROB_DEPTH;
  localparam int N_CHAIN = 12;
  localparam int N_BURST = 12;
  localparam int N_CONT  = 18;
  localparam int N_RAND  = 40;
  localparam int N_TOTAL = N_CHAIN + N_BURST + N_CONT + N_RAND;
  localparam int WATCHDOG_NS = N_TOTAL * 40 * 8 + 2000;  // 40 cycles per instruction

  logic                   clock, reset, in_valid;
  ooo_isa_pkg::op_e       in_op;
  ooo_isa_pkg::arch_reg_t in_dest, in_src1, in_src2;
  ooo_isa_pkg::word_t     in_imm;
  logic                   credit_return, commit_valid;
  ooo_isa_pkg::arch_reg_t commit_dest;
  ooo_isa_pkg::word_t     commit_data;

  ooo_isa_pkg::word_t     ref_regs [`OOO_ARCH_REGS];  // architectural state, program order
  ooo_isa_pkg::arch_reg_t exp_dest_q [$];             // dispatched, not yet committed
  ooo_isa_pkg::word_t     exp_data_q [$];
  ooo_isa_pkg::arch_reg_t head_dest;
  ooo_isa_pkg::word_t     head_data;
  logic                   head_valid;
  int                     sent, returned, commits, credits;
  int                     errors, tests_passed, tests_failed;
  logic                   stall_seen;
  integer                 seed;

  assign credits = DEPTH - sent + returned;  // credits the source still holds

  ooo_core dut_i (
    .clock, .reset, .in_valid, .in_op, .in_dest, .in_src1, .in_src2, .in_imm,
    .credit_return, .commit_valid, .commit_dest, .commit_data
  );

  always #4 clock = ~clock;  // 8 ns period

  //////////////////////////////////////////////////////////////////////////
  // expected head of the in-order queue
  //////////////////////////////////////////////////////////////////////////
  function automatic void refresh_head();
    head_valid = (exp_dest_q.size() != 0);
    if (head_valid) begin
      head_dest = exp_dest_q[0];
      head_data = exp_data_q[0];
    end
  endfunction

  // retirement lands on this edge, so the head moves on
  always @(posedge clock) begin
    if (!reset) begin
      if (credit_return) returned++;
      if (commit_valid) begin
        commits++;
        if (exp_dest_q.size() != 0) begin
          void'(exp_dest_q.pop_front());
          void'(exp_data_q.pop_front());
        end
        refresh_head();
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////////
  a_idle_commit: assert property (@(posedge clock) disable iff (reset)
      (sent == 0) |-> !commit_valid)
    else begin
      errors++;
      $display("[ERROR] %0t commit_valid expected 0 actual %0b", $time,
               $sampled(commit_valid));
    end

  a_idle_credit: assert property (@(posedge clock) disable iff (reset)
      (sent == 0) |-> !credit_return)
    else begin
      errors++;
      $display("[ERROR] %0t credit_return expected 0 actual %0b", $time,
               $sampled(credit_return));
    end

  a_outstanding: assert property (@(posedge clock) disable iff (reset)
      commit_valid |-> head_valid)
    else begin
      errors++;
      $display("%0t: a commit arrived with no instruction outstanding", $time);
    end

  a_dest: assert property (@(posedge clock) disable iff (reset)
      (commit_valid && head_valid) |-> (commit_dest == head_dest))
    else begin
      errors++;
      $display("[ERROR] %0t commit_dest expected %0d actual %0d", $time,
               $sampled(head_dest), $sampled(commit_dest));
    end

  a_data: assert property (@(posedge clock) disable iff (reset)
      (commit_valid && head_valid) |-> (commit_data == head_data))
    else begin
      errors++;
      $display("[ERROR] %0t commit_data expected %h actual %h", $time,
               $sampled(head_data), $sampled(commit_data));
    end

  a_credit_range: assert property (@(posedge clock) disable iff (reset)
      (credits >= 0 && credits <= DEPTH))
    else begin
      errors++;
      $display("%0t: dispatch credits left the range 0 to %0d", $time, DEPTH);
    end

  //////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////////
  // one dispatch at a falling edge, stalls while no credit is held
  task automatic send(input ooo_isa_pkg::op_e op, input ooo_isa_pkg::arch_reg_t dest,
                      input ooo_isa_pkg::arch_reg_t src1, input ooo_isa_pkg::arch_reg_t src2,
                      input ooo_isa_pkg::word_t imm);
    ooo_isa_pkg::word_t result;
    while (credits == 0) begin
      stall_seen = 1'b1;
      @(negedge clock);
    end
    case (op)
      ooo_isa_pkg::ADD: result = ref_regs[src1] + ref_regs[src2];
      ooo_isa_pkg::SUB: result = ref_regs[src1] - ref_regs[src2];
      ooo_isa_pkg::MUL: result = ref_regs[src1] * ref_regs[src2];  // low word
      default:          result = imm;
    endcase
    ref_regs[dest] = result;
    in_valid = 1'b1;
    in_op    = op;
    in_dest  = dest;
    in_src1  = src1;
    in_src2  = src2;
    in_imm   = imm;
    exp_dest_q.push_back(dest);
    exp_data_q.push_back(result);
    sent++;
    refresh_head();
    @(negedge clock);
    in_valid = 1'b0;
  endtask

  // wait for every outstanding commit, then report the test
  task automatic finish_test(input string name, input int n, input int err_start);
    while (exp_dest_q.size() != 0 || credits != DEPTH) @(negedge clock);
    if (errors == err_start) tests_passed++;
    else tests_failed++;
    $display("test %s: %0d instructions, %0d errors", name, n, errors - err_start);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////////////////////////////
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired with %0d instructions still outstanding",
             exp_dest_q.size());
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////////
  initial begin
    int         err_start;
    logic [31:0] rnd;
    ooo_isa_pkg::op_e rop;
    seed         = 32'h8c9b;
    clock        = 1'b0;
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_op        = ooo_isa_pkg::ADD;
    in_dest      = '0;
    in_src1      = '0;
    in_src2      = '0;
    in_imm       = '0;
    sent         = 0;
    returned     = 0;
    commits      = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    stall_seen   = 1'b0;
    head_valid   = 1'b0;
    head_dest    = '0;
    head_data    = '0;
    for (int r = 0; r < `OOO_ARCH_REGS; r++) ref_regs[r] = '0;  // regs read 0 after reset

    repeat (3) @(negedge clock);
    reset = 1'b0;

    // quiet core, nothing dispatched
    err_start = errors;
    repeat (6) @(negedge clock);
    finish_test("reset_idle", 0, err_start);

    // dependent chain through renamed registers
    err_start = errors;
    send(ooo_isa_pkg::LI,  3'd1, 3'd0, 3'd0, 32'd5);
    send(ooo_isa_pkg::LI,  3'd2, 3'd0, 3'd0, 32'd7);
    send(ooo_isa_pkg::ADD, 3'd3, 3'd1, 3'd2, 32'd0);
    send(ooo_isa_pkg::SUB, 3'd4, 3'd3, 3'd1, 32'd0);
    send(ooo_isa_pkg::MUL, 3'd5, 3'd3, 3'd4, 32'd0);
    send(ooo_isa_pkg::ADD, 3'd1, 3'd5, 3'd5, 32'd0);  // r1 renamed again
    send(ooo_isa_pkg::MUL, 3'd6, 3'd1, 3'd2, 32'd0);
    send(ooo_isa_pkg::SUB, 3'd7, 3'd6, 3'd3, 32'd0);
    send(ooo_isa_pkg::LI,  3'd0, 3'd0, 3'd0, 32'hffff_ffff);
    send(ooo_isa_pkg::ADD, 3'd2, 3'd0, 3'd7, 32'd0);
    send(ooo_isa_pkg::MUL, 3'd3, 3'd2, 3'd2, 32'd0);
    send(ooo_isa_pkg::SUB, 3'd1, 3'd1, 3'd1, 32'd0);
    finish_test("dependent_chain", N_CHAIN, err_start);

    // 8 back to back, then the source runs dry and waits
    err_start  = errors;
    stall_seen = 1'b0;
    for (int i = 0; i < N_BURST; i++) begin
      if (i == 0) send(ooo_isa_pkg::MUL, 3'd0, 3'd1, 3'd2, 32'd0);  // slow head, blocks retire
      else if (i % 3 == 0) send(ooo_isa_pkg::ADD, 3'(i), 3'(i + 1), 3'(i + 2), 32'd0);
      else send(ooo_isa_pkg::LI, 3'(i), 3'd0, 3'd0, 32'(i * 32'h0101_0101));
    end
    assert (stall_seen)
      else begin
        errors++;
        $display("%0t: the burst never stalled waiting for a credit", $time);
      end
    finish_test("credit_burst", N_BURST, err_start);

    // multiplier and alu results fight for the bus
    err_start = errors;
    send(ooo_isa_pkg::LI, 3'd1, 3'd0, 3'd0, 32'd3);
    send(ooo_isa_pkg::LI, 3'd2, 3'd0, 3'd0, 32'd11);
    for (int i = 0; i < 8; i++) begin
      while (exp_dest_q.size() != 0) @(negedge clock);  // start each pair on an idle core
      send(ooo_isa_pkg::MUL, 3'(4 + i % 4), 3'd1, 3'd2, 32'd0);
      repeat (28 + i % 5) @(negedge clock);  // add request swept across the mult done cycle
      send(ooo_isa_pkg::ADD, (i % 2 == 0) ? 3'd0 : 3'd3, 3'd1, 3'd2, 32'd0);
    end
    finish_test("bus_contention", N_CONT, err_start);

    // random mix from the fixed seed
    err_start = errors;
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      rop = ooo_isa_pkg::op_e'(rnd[1:0]);
      send(rop, rnd[4:2], rnd[7:5], rnd[10:8], $random(seed));
    end
    finish_test("random_mix", N_RAND, err_start);

    assert (returned == commits)
      else begin
        errors++;
        $display("[ERROR] %0t credit_return total expected %0d actual %0d", $time,
                 commits, returned);
      end

    $display("tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
